/* verilog/axis_defines.svh */
`ifndef AXIS_DEFINES_SVH
`define AXIS_DEFINES_SVH

// ====================================================================
// Stream pipeline build parameters
// ====================================================================

// Bytes per beat on every stream link
`define AXIS_DATA_BYTES 8

// Entries in the FIFO stage
// Must stay a power of two so the wrap bit compare works
`define AXIS_FIFO_DEPTH 4

`endif

/* verilog/axis_pkg.sv */
`default_nettype none

`include "axis_defines.svh"

package axis_pkg;

    // ================================================================
    // Beat field types
    // ================================================================

    // Data bus width in bits
    localparam int AXIS_DATA_BITS = `AXIS_DATA_BYTES * 8;

    // Beat data
    typedef logic [AXIS_DATA_BITS-1:0] axis_data_t;

    // Byte enables, one per data byte
    typedef logic [`AXIS_DATA_BYTES-1:0] axis_keep_t;

endpackage

`default_nettype wire

/* verilog/axis_skid_buf.sv */
`timescale 1ns/10ps
`default_nettype none

module axis_skid_buf (
    input  logic                 aclk,
    input  logic                 arst_n,
    // Slave side
    input  logic                 s_tvalid,
    output logic                 s_tready,
    input  axis_pkg::axis_data_t s_tdata,
    input  axis_pkg::axis_keep_t s_tkeep,
    input  logic                 s_tlast,
    // Master side
    output logic                 m_tvalid,
    input  logic                 m_tready,
    output axis_pkg::axis_data_t m_tdata,
    output axis_pkg::axis_keep_t m_tkeep,
    output logic                 m_tlast
);
    import axis_pkg::*;

    // Skid register holding one beat caught during a stall
    axis_data_t skid_tdata;
    axis_keep_t skid_tkeep;
    logic       skid_tlast;
    logic       skid_valid;
    logic       skid_valid_nxt;

    logic in_xfer;
    logic out_free;
    logic out_load;
    logic skid_load;
    logic skid_unload;

    // ================================================================
    // Handshake decode
    // ================================================================

    assign in_xfer     = s_tvalid & s_tready;
    // Output register can take a beat this cycle
    assign out_free    = m_tready | ~m_tvalid;
    assign out_load    = in_xfer & out_free;
    assign skid_load   = in_xfer & ~out_free;
    assign skid_unload = skid_valid & out_free;

    assign skid_valid_nxt = (skid_valid & ~out_free) | skid_load;

    // ================================================================
    // Control state
    // ================================================================

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            m_tvalid   <= 1'b0;
            skid_valid <= 1'b0;
            s_tready   <= 1'b0;
        end else begin
            if (out_free) begin
                m_tvalid <= skid_valid | in_xfer;
            end
            skid_valid <= skid_valid_nxt;
            // Ready is taken from the flop, not from m_tready
            s_tready   <= ~skid_valid_nxt;
        end
    end

    // ================================================================
    // Payload
    // ================================================================

    // Skid beat always leaves before a new input beat
    always_ff @(posedge aclk) begin
        if (skid_unload) begin
            m_tdata <= skid_tdata;
            m_tkeep <= skid_tkeep;
            m_tlast <= skid_tlast;
        end else if (out_load) begin
            m_tdata <= s_tdata;
            m_tkeep <= s_tkeep;
            m_tlast <= s_tlast;
        end
    end

    always_ff @(posedge aclk) begin
        if (skid_load) begin
            skid_tdata <= s_tdata;
            skid_tkeep <= s_tkeep;
            skid_tlast <= s_tlast;
        end
    end

    // ================================================================
    // Checks
    // ================================================================

    // Stalled output beat is held unchanged
    a_out_hold: assert property (@(posedge aclk) disable iff (!arst_n)
        m_tvalid && !m_tready |=>
            m_tvalid && $stable(m_tdata) && $stable(m_tkeep) && $stable(m_tlast))
        else $error("skid output changed while stalled");

    // Registered ready must keep a full skid register from reloading
    a_skid_no_overwrite: assert property (@(posedge aclk) disable iff (!arst_n)
        skid_load |-> !skid_valid)
        else $error("skid register loaded while full");

endmodule

`default_nettype wire

/* verilog/axis_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

`include "axis_defines.svh"

module axis_fifo (
    input  logic                 aclk,
    input  logic                 arst_n,
    // Slave side
    input  logic                 s_tvalid,
    output logic                 s_tready,
    input  axis_pkg::axis_data_t s_tdata,
    input  axis_pkg::axis_keep_t s_tkeep,
    input  logic                 s_tlast,
    // Master side
    output logic                 m_tvalid,
    input  logic                 m_tready,
    output axis_pkg::axis_data_t m_tdata,
    output axis_pkg::axis_keep_t m_tkeep,
    output logic                 m_tlast
);
    import axis_pkg::*;

    localparam int DEPTH = `AXIS_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    // Circular storage, one array per beat field
    axis_data_t mem_tdata [DEPTH];
    axis_keep_t mem_tkeep [DEPTH];
    logic       mem_tlast [DEPTH];

    // Pointers with an extra wrap bit on top
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;
    logic [PTR_W:0] mem_count;

    logic mem_empty;
    logic mem_full;
    logic in_xfer;
    logic out_free;
    logic bypass;
    logic mem_wr;
    logic mem_rd;

    // ================================================================
    // Status and handshake decode
    // ================================================================

    assign mem_empty = (wr_ptr == rd_ptr);
    // Same index, opposite wrap bit
    assign mem_full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                       (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    // Entries held in the array, modulo the doubled pointer range
    assign mem_count = wr_ptr - rd_ptr;

    assign s_tready = ~mem_full;
    assign in_xfer  = s_tvalid & s_tready;
    assign out_free = m_tready | ~m_tvalid;

    // Empty storage and a free head register let the beat skip the array
    assign bypass = in_xfer & out_free & mem_empty;
    assign mem_wr = in_xfer & ~bypass;
    assign mem_rd = out_free & ~mem_empty;

    // ================================================================
    // Storage array
    // ================================================================

    always_ff @(posedge aclk) begin
        if (mem_wr) begin
            mem_tdata[wr_ptr[PTR_W-1:0]] <= s_tdata;
            mem_tkeep[wr_ptr[PTR_W-1:0]] <= s_tkeep;
            mem_tlast[wr_ptr[PTR_W-1:0]] <= s_tlast;
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (mem_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (mem_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // ================================================================
    // Registered head entry
    // ================================================================

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            m_tvalid <= 1'b0;
        end else if (out_free) begin
            m_tvalid <= mem_rd | bypass;
        end
    end

    // Oldest stored beat wins over the bypass path
    always_ff @(posedge aclk) begin
        if (mem_rd) begin
            m_tdata <= mem_tdata[rd_ptr[PTR_W-1:0]];
            m_tkeep <= mem_tkeep[rd_ptr[PTR_W-1:0]];
            m_tlast <= mem_tlast[rd_ptr[PTR_W-1:0]];
        end else if (bypass) begin
            m_tdata <= s_tdata;
            m_tkeep <= s_tkeep;
            m_tlast <= s_tlast;
        end
    end

    // ================================================================
    // Checks
    // ================================================================

    // A write past full would push the count beyond the depth
    a_no_write_full: assert property (@(posedge aclk) disable iff (!arst_n)
        mem_wr |=> mem_count <= DEPTH)
        else $error("fifo written while full");

    // A read from empty would wrap the count to the top of its range
    a_no_read_empty: assert property (@(posedge aclk) disable iff (!arst_n)
        mem_rd |=> mem_count < DEPTH)
        else $error("fifo read while empty");

endmodule

`default_nettype wire

/* verilog/axis_fwd_reg.sv */
`timescale 1ns/10ps
`default_nettype none

module axis_fwd_reg (
    input  logic                 aclk,
    input  logic                 arst_n,
    // Slave side
    input  logic                 s_tvalid,
    output logic                 s_tready,
    input  axis_pkg::axis_data_t s_tdata,
    input  axis_pkg::axis_keep_t s_tkeep,
    input  logic                 s_tlast,
    // Master side
    output logic                 m_tvalid,
    input  logic                 m_tready,
    output axis_pkg::axis_data_t m_tdata,
    output axis_pkg::axis_keep_t m_tkeep,
    output logic                 m_tlast
);
    import axis_pkg::*;

    logic in_xfer;

    // ================================================================
    // Handshake
    // ================================================================

    // Register is free when empty or emptying this cycle
    assign s_tready = ~m_tvalid | m_tready;
    assign in_xfer  = s_tvalid & s_tready;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            m_tvalid <= 1'b0;
        end else if (s_tready) begin
            m_tvalid <= s_tvalid;
        end
    end

    // ================================================================
    // Payload
    // ================================================================

    always_ff @(posedge aclk) begin
        if (in_xfer) begin
            m_tdata <= s_tdata;
            m_tkeep <= s_tkeep;
            m_tlast <= s_tlast;
        end
    end

    // Sink sees the same beat until it takes it
    a_out_hold: assert property (@(posedge aclk) disable iff (!arst_n)
        m_tvalid && !m_tready |=>
            m_tvalid && $stable(m_tdata) && $stable(m_tkeep) && $stable(m_tlast))
        else $error("forward register output changed while stalled");

endmodule

`default_nettype wire

/* verilog/axis_pipe_top.sv */
`timescale 1ns/10ps
`default_nettype none

module axis_pipe_top (
    input  logic                 aclk,
    input  logic                 arst_n,
    // Slave side
    input  logic                 s_tvalid,
    output logic                 s_tready,
    input  axis_pkg::axis_data_t s_tdata,
    input  axis_pkg::axis_keep_t s_tkeep,
    input  logic                 s_tlast,
    // Master side
    output logic                 m_tvalid,
    input  logic                 m_tready,
    output axis_pkg::axis_data_t m_tdata,
    output axis_pkg::axis_keep_t m_tkeep,
    output logic                 m_tlast
);
    import axis_pkg::*;

    // Skid buffer to FIFO
    logic       skid_tvalid;
    logic       skid_tready;
    axis_data_t skid_tdata;
    axis_keep_t skid_tkeep;
    logic       skid_tlast;

    // FIFO to forward register
    logic       fifo_tvalid;
    logic       fifo_tready;
    axis_data_t fifo_tdata;
    axis_keep_t fifo_tkeep;
    logic       fifo_tlast;

    // ================================================================
    // Stage chain
    // ================================================================

    axis_skid_buf u_skid (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .s_tdata  (s_tdata),
        .s_tkeep  (s_tkeep),
        .s_tlast  (s_tlast),
        .m_tvalid (skid_tvalid),
        .m_tready (skid_tready),
        .m_tdata  (skid_tdata),
        .m_tkeep  (skid_tkeep),
        .m_tlast  (skid_tlast)
    );

    axis_fifo u_fifo (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .s_tvalid (skid_tvalid),
        .s_tready (skid_tready),
        .s_tdata  (skid_tdata),
        .s_tkeep  (skid_tkeep),
        .s_tlast  (skid_tlast),
        .m_tvalid (fifo_tvalid),
        .m_tready (fifo_tready),
        .m_tdata  (fifo_tdata),
        .m_tkeep  (fifo_tkeep),
        .m_tlast  (fifo_tlast)
    );

    axis_fwd_reg u_fwd (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .s_tvalid (fifo_tvalid),
        .s_tready (fifo_tready),
        .s_tdata  (fifo_tdata),
        .s_tkeep  (fifo_tkeep),
        .s_tlast  (fifo_tlast),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .m_tdata  (m_tdata),
        .m_tkeep  (m_tkeep),
        .m_tlast  (m_tlast)
    );

endmodule

`default_nettype wire

/* test/axis_pipe_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "axis_defines.svh"

module axis_pipe_tb;
    import axis_pkg::*;

    localparam int BEAT_W     = AXIS_DATA_BITS + `AXIS_DATA_BYTES + 1;
    // Skid output, skid register, FIFO array, FIFO head, forward register
    localparam int PIPE_SLOTS = `AXIS_FIFO_DEPTH + 4;
    localparam int LATENCY    = 3;
    // Worst case drain with a two-cycle sink stall after every beat
    localparam int DRAIN_CYCLES = PIPE_SLOTS * 3 + LATENCY + 20;
    // 401 packets of at most 16 beats each
    localparam int MAX_BEATS  = 401 * 16;
    localparam int TIMEOUT_CYCLES = MAX_BEATS * 40 + 2000;

    typedef logic [BEAT_W-1:0] beat_t;

    logic       aclk;
    logic       arst_n;
    logic       s_tvalid;
    logic       s_tready;
    axis_data_t s_tdata;
    axis_keep_t s_tkeep;
    logic       s_tlast;
    logic       m_tvalid;
    logic       m_tready;
    axis_data_t m_tdata;
    axis_keep_t m_tkeep;
    logic       m_tlast;

    // Expected beats {tlast, tkeep, tdata} and their input cycle
    beat_t exp_q[$];
    int    in_cycle_q[$];

    int    cycle;
    int    max_wait;
    int    wait_left;
    bit    latency_check;
    bit    fill_check_on;
    int    in_stalls;
    int    out_count;
    int    first_out_cycle;
    int    last_out_cycle;
    int    ready_low_cycles;
    beat_t exp_beat;
    int    in_cyc;

    axis_pipe_top u_dut (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .s_tdata  (s_tdata),
        .s_tkeep  (s_tkeep),
        .s_tlast  (s_tlast),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .m_tdata  (m_tdata),
        .m_tkeep  (m_tkeep),
        .m_tlast  (m_tlast)
    );

    always #10 aclk = ~aclk;

    always @(posedge aclk) begin
        cycle <= cycle + 1;
    end

    // ====================================================================
    // Reference model and compare
    // ====================================================================

    // The pipeline is an identity, so the next output is the oldest input
    function automatic beat_t expected_beat();
        return exp_q.pop_front();
    endfunction

    task automatic check_equal(input string what, input logic [AXIS_DATA_BITS-1:0] actual,
                               input logic [AXIS_DATA_BITS-1:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s mismatch, got %h expected %h",
                     $time, what, actual, expected);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    always @(posedge aclk) begin
        if (arst_n && m_tvalid && m_tready) begin
            if (exp_q.size() == 0) begin
                $display("Output beat at %0t has no matching input beat", $time);
                $display("=== FAIL ===");
                $fatal(1);
            end else begin
                exp_beat = expected_beat();
                in_cyc   = in_cycle_q.pop_front();
                check_equal("tdata", m_tdata, exp_beat[AXIS_DATA_BITS-1:0]);
                check_equal("tkeep", m_tkeep, exp_beat[AXIS_DATA_BITS +: `AXIS_DATA_BYTES]);
                check_equal("tlast", m_tlast, exp_beat[BEAT_W-1]);
                if (latency_check) begin
                    check_equal("latency", cycle - in_cyc, LATENCY);
                end
                if (out_count == 0) begin
                    first_out_cycle = cycle;
                end
                last_out_cycle = cycle;
                out_count++;
                if (max_wait > 0) begin
                    wait_left = $urandom_range(0, max_wait);
                end
            end
        end
    end

    // Input side may only back up once the stages hold their beats
    always @(negedge aclk) begin
        if (fill_check_on && !s_tready) begin
            ready_low_cycles++;
            check_equal("beats held while s_tready low", exp_q.size() >= PIPE_SLOTS - 1, 1);
        end
    end

    // ====================================================================
    // Sink and source
    // ====================================================================

    always @(negedge aclk) begin
        if (wait_left > 0) begin
            m_tready = 1'b0;
            wait_left--;
        end else begin
            m_tready = 1'b1;
        end
    end

    task automatic drive_beat(input axis_data_t data, input axis_keep_t keep,
                              input logic last);
        s_tvalid = 1'b1;
        s_tdata  = data;
        s_tkeep  = keep;
        s_tlast  = last;
        @(posedge aclk);
        while (!s_tready) begin
            in_stalls++;
            @(posedge aclk);
        end
        exp_q.push_back({last, keep, data});
        in_cycle_q.push_back(cycle);
        @(negedge aclk);
    endtask

    task automatic send_packet(input int max_pause);
        int         len;
        int         pause;
        int         nbytes;
        axis_data_t data;
        axis_keep_t keep;
        len = $urandom_range(1, 16);
        for (int i = 0; i < len; i++) begin
            pause = (max_pause > 0) ? $urandom_range(0, max_pause) : 0;
            if (pause > 0) begin
                s_tvalid = 1'b0;
                repeat (pause) @(negedge aclk);
            end
            for (int b = 0; b < `AXIS_DATA_BYTES; b++) begin
                data[8*b +: 8] = $urandom;
            end
            keep = '1;
            // Last beat gets a contiguous low byte mask
            if (i == len - 1) begin
                nbytes = $urandom_range(1, `AXIS_DATA_BYTES);
                keep = '0;
                for (int b = 0; b < nbytes; b++) begin
                    keep[b] = 1'b1;
                end
            end
            drive_beat(data, keep, i == len - 1);
        end
    endtask

    task automatic run_phase(input string name, input int packets, input int pause,
                             input int stall);
        int drain;
        max_wait      = stall;
        latency_check = (stall == 0);
        in_stalls     = 0;
        out_count     = 0;
        $display("Running %s", name);
        for (int p = 0; p < packets; p++) begin
            send_packet(pause);
        end
        s_tvalid = 1'b0;
        drain    = 0;
        while (exp_q.size() != 0 && drain < DRAIN_CYCLES) begin
            @(negedge aclk);
            drain++;
        end
        if (stall == 0) begin
            check_equal("input stall cycles", in_stalls, 0);
        end
        if (stall == 0 && pause == 0) begin
            check_equal("full-rate output span", last_out_cycle - first_out_cycle + 1,
                        out_count);
        end
        // Let a pending sink stall run out before the next phase
        repeat (4) @(negedge aclk);
    endtask

    // ====================================================================
    // Main sequence and watchdog
    // ====================================================================

    initial begin
        void'($urandom(32'hc13f_3469));
        aclk             = 1'b0;
        arst_n           = 1'b0;
        s_tvalid         = 1'b0;
        s_tdata          = '0;
        s_tkeep          = '0;
        s_tlast          = 1'b0;
        m_tready         = 1'b0;
        cycle            = 0;
        max_wait         = 0;
        wait_left        = 0;
        latency_check    = 1'b0;
        fill_check_on    = 1'b0;
        ready_low_cycles = 0;
        repeat (10) begin
            @(negedge aclk);
            check_equal("m_tvalid in reset", m_tvalid, 0);
            check_equal("s_tready in reset", s_tready, 0);
        end
        arst_n = 1'b1;
        @(negedge aclk);
        check_equal("s_tready after reset", s_tready, 1);
        fill_check_on = 1'b1;

        run_phase("single packet after reset", 1, 0, 0);
        run_phase("full-rate stream", 100, 0, 0);
        run_phase("source gaps", 100, 2, 0);
        ready_low_cycles = 0;
        run_phase("sink stalls", 100, 0, 2);
        check_equal("s_tready dropped under stalls", ready_low_cycles > 0, 1);
        run_phase("source gaps and sink stalls", 100, 2, 2);

        if (exp_q.size() == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("Expected queue still holds %0d beats at the end", exp_q.size());
            $display("=== FAIL ===");
            $fatal(1);
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge aclk);
        $display("Timeout: the pipeline stalled and not all beats came out");
        $display("=== FAIL ===");
        $fatal(1);
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+verilog
verilog/axis_pkg.sv
verilog/axis_skid_buf.sv
verilog/axis_fifo.sv
verilog/axis_fwd_reg.sv
verilog/axis_pipe_top.sv
test/axis_pipe_tb.sv
